// File: Makefile
# Verilator build and run for the command buffer testbench

VERILATOR ?= verilator
TOP       ?= cmd_buffer_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/cmd_buffer_pkg.sv
// -------------------------------------------------------------------------
// Command buffer package
// Widths, queue depths, command codes and the structs shared by the
// request, decode, execute and response stages
// -------------------------------------------------------------------------

package cmd_buffer_pkg;

  // -------------------------------------------------------------------------
  // Widths and depths
  // -------------------------------------------------------------------------
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = 4;
  localparam int TAG_W       = 8;
  localparam int PAYLOAD_W   = DATA_W + STRB_W;
  localparam int FIFO_DEPTH  = 16;
  localparam int PROG_THRESH = 12;

  // Command codes, anything else is a no-op
  typedef enum logic [1:0] {
    CMD_MEM_READ  = 2'd1,
    CMD_MEM_WRITE = 2'd2
  } cmd_e;

  // Execute stage states
  typedef enum logic [1:0] {
    EXEC_IDLE  = 2'd0,
    EXEC_ISSUE = 2'd1,
    EXEC_WAIT  = 2'd2
  } exec_state_e;

  // -------------------------------------------------------------------------
  // Payload word, two readings of the same 36 bits
  // -------------------------------------------------------------------------
  // Write view, strobes in the low nibble
  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } wr_view_t;

  // Read view, tag in the top byte so it never overlaps the strobes
  typedef struct packed {
    logic [TAG_W-1:0]           tag;
    logic [PAYLOAD_W-TAG_W-1:0] pad;
  } rd_view_t;

  typedef union packed {
    wr_view_t wr_view;
    rd_view_t rd_view;
  } cmd_payload_u;

  // -------------------------------------------------------------------------
  // Stage structs
  // -------------------------------------------------------------------------
  // Incoming command
  typedef struct packed {
    logic              valid;
    cmd_e              cmd;
    logic [ADDR_W-1:0] addr;
    cmd_payload_u      payload;
  } cmd_req_t;

  // Decoded head command
  typedef struct packed {
    cmd_e              cmd;
    logic              write;
    logic [ADDR_W-1:0] addr;
    cmd_payload_u      payload;
  } cmd_op_t;

  // Single-beat memory request, valid is a pulse
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  // Memory reply, valid is a pulse
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Response to the consumer
  typedef struct packed {
    logic              valid;
    cmd_e              cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [TAG_W-1:0]  tag;
  } cmd_rsp_t;

endpackage : cmd_buffer_pkg

// File: design/cmd_buffer_top.sv
// -------------------------------------------------------------------------
// Memory command buffer top level
// Request queue, decode, execute and response stages with drain flag
// -------------------------------------------------------------------------

module cmd_buffer_top (
  input  logic                     ap_clk,
  input  logic                     areset_m_axi,
  input  cmd_buffer_pkg::cmd_req_t cmd_in,
  output logic                     cmd_prog_full,
  output cmd_buffer_pkg::mem_req_t mem_req,
  input  cmd_buffer_pkg::mem_rsp_t mem_rsp,
  output cmd_buffer_pkg::cmd_rsp_t resp_out,
  input  logic                     resp_ready,
  output logic                     done_out
);

  // -------------------------------------------------------------------------
  // Stage wires
  // -------------------------------------------------------------------------
  cmd_buffer_pkg::cmd_req_t cmd_in_q;
  cmd_buffer_pkg::cmd_req_t req_head;
  logic                     req_empty;
  logic                     req_pop;
  logic                     op_valid;
  logic                     op_take;
  cmd_buffer_pkg::cmd_op_t  op;
  logic                     result_valid;
  cmd_buffer_pkg::cmd_rsp_t result;
  logic                     resp_space;
  logic                     resp_empty;
  logic                     exec_busy;
  logic                     drained;

  // Input register, only valid is cleared
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      cmd_in_q.valid <= 1'b0;
    end else begin
      cmd_in_q <= cmd_in;
    end
  end

  // Request queue
  cmd_fifo #(
    .WIDTH($bits(cmd_buffer_pkg::cmd_req_t)),
    .DEPTH(cmd_buffer_pkg::FIFO_DEPTH)
  ) u_req_fifo (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .din         (cmd_in_q),
    .push        (cmd_in_q.valid),
    .pop         (req_pop),
    .dout        (req_head),
    .full        (),
    .empty       (req_empty),
    .prog_full   (cmd_prog_full)
  );

  cmd_decode u_decode (
    .ap_clk(ap_clk), .areset_m_axi(areset_m_axi), .head(req_head),
    .head_empty(req_empty), .head_pop(req_pop), .op_take(op_take),
    .op_valid(op_valid), .op(op)
  );

  mem_execute u_execute (
    .ap_clk(ap_clk), .areset_m_axi(areset_m_axi), .op_valid(op_valid), .op(op),
    .op_take(op_take), .resp_space(resp_space), .mem_req(mem_req), .mem_rsp(mem_rsp),
    .result_valid(result_valid), .result(result), .busy(exec_busy)
  );

  resp_result u_result (
    .ap_clk(ap_clk), .areset_m_axi(areset_m_axi), .result_valid(result_valid),
    .result(result), .resp_ready(resp_ready), .resp_out(resp_out),
    .resp_space(resp_space), .resp_empty(resp_empty)
  );

  // -------------------------------------------------------------------------
  // Drain flag
  // -------------------------------------------------------------------------
  // Nothing staged, queued, held or in flight
  assign drained = ~cmd_in_q.valid & req_empty & ~op_valid & ~exec_busy & resp_empty;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      done_out <= 1'b0;
    end else begin
      done_out <= drained;
    end
  end

endmodule : cmd_buffer_top

// File: design/cmd_decode.sv
// -------------------------------------------------------------------------
// Command decode stage
// Holds the decoded head command, masks strobes of non-writes and
// drops unknown command codes
// -------------------------------------------------------------------------

module cmd_decode (
  input  logic                     ap_clk,
  input  logic                     areset_m_axi,
  input  cmd_buffer_pkg::cmd_req_t head,
  input  logic                     head_empty,
  output logic                     head_pop,
  input  logic                     op_take,
  output logic                     op_valid,
  output cmd_buffer_pkg::cmd_op_t  op
);

  logic                    load;
  logic                    head_ok;
  logic                    head_wr;
  cmd_buffer_pkg::cmd_op_t op_next;

  // Classify the head command
  assign head_wr = (head.cmd == cmd_buffer_pkg::CMD_MEM_WRITE);
  assign head_ok = head.valid & (head_wr | (head.cmd == cmd_buffer_pkg::CMD_MEM_READ));

  // Refill when the op register is free or leaving this cycle
  assign load     = ~head_empty & (~op_valid | op_take);
  assign head_pop = load;

  // -------------------------------------------------------------------------
  // Decoded op
  // -------------------------------------------------------------------------
  always_comb begin
    op_next.cmd     = head.cmd;
    op_next.write   = head_wr;
    op_next.addr    = head.addr;
    op_next.payload = head.payload;
    // Reads keep the tag, only the strobe nibble is cleared
    if (!head_wr) begin
      op_next.payload.wr_view.wstrb = '0;
    end
  end

  // Occupancy of the op register
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      op_valid <= 1'b0;
    end else if (load) begin
      // Unknown codes are popped but never raise op_valid
      op_valid <= head_ok;
    end else if (op_take) begin
      op_valid <= 1'b0;
    end
  end

  // Op payload
  always_ff @(posedge ap_clk) begin
    if (load) begin
      op <= op_next;
    end
  end

endmodule : cmd_decode

// File: design/cmd_fifo.sv
// -------------------------------------------------------------------------
// Synchronous first-word-fall-through queue
// Circular buffer with full, empty and programmable-full flags
// -------------------------------------------------------------------------

module cmd_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             areset_m_axi,
  input  logic [WIDTH-1:0] din,
  input  logic             push,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             prog_full
);

  // Storage and pointers
  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  // Push while full and pop while empty are dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // Flags straight from the count
  assign full      = (count == DEPTH);
  assign empty     = (count == 0);
  assign prog_full = (count >= cmd_buffer_pkg::PROG_THRESH);

  // Head always visible
  assign dout = mem[rd_ptr];

  // -------------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap for depths that are not a power of two
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Entry storage
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule : cmd_fifo

// File: design/mem_execute.sv
// -------------------------------------------------------------------------
// Memory execute stage
// Issues one single-beat access per command and waits for the reply,
// then hands the completed access to the result stage
// -------------------------------------------------------------------------

module mem_execute (
  input  logic                     ap_clk,
  input  logic                     areset_m_axi,
  input  logic                     op_valid,
  input  cmd_buffer_pkg::cmd_op_t  op,
  output logic                     op_take,
  input  logic                     resp_space,
  output cmd_buffer_pkg::mem_req_t mem_req,
  input  cmd_buffer_pkg::mem_rsp_t mem_rsp,
  output logic                     result_valid,
  output cmd_buffer_pkg::cmd_rsp_t result,
  output logic                     busy
);

  cmd_buffer_pkg::exec_state_e state;
  cmd_buffer_pkg::exec_state_e state_next;
  cmd_buffer_pkg::cmd_op_t     op_q;
  logic                        start;
  logic                        reply;

  // Leave idle only with room downstream
  assign start = (state == cmd_buffer_pkg::EXEC_IDLE) & op_valid & resp_space;
  assign reply = (state == cmd_buffer_pkg::EXEC_WAIT) & mem_rsp.valid;

  // Decode releases its op in the issue cycle
  assign op_take = (state == cmd_buffer_pkg::EXEC_ISSUE);

  // Pending result pulse still counts as busy for drain detection
  assign busy = (state != cmd_buffer_pkg::EXEC_IDLE) | result_valid;

  // -------------------------------------------------------------------------
  // FSM
  // -------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      cmd_buffer_pkg::EXEC_IDLE:  if (start) state_next = cmd_buffer_pkg::EXEC_ISSUE;
      cmd_buffer_pkg::EXEC_ISSUE: state_next = cmd_buffer_pkg::EXEC_WAIT;
      cmd_buffer_pkg::EXEC_WAIT:  if (mem_rsp.valid) state_next = cmd_buffer_pkg::EXEC_IDLE;
      default:                    state_next = cmd_buffer_pkg::EXEC_IDLE;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state <= cmd_buffer_pkg::EXEC_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // -------------------------------------------------------------------------
  // Memory request, valid high for the issue cycle only
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      mem_req.valid <= 1'b0;
    end else begin
      mem_req.valid <= start;
    end
    if (start) begin
      op_q          <= op;
      mem_req.write <= op.write;
      mem_req.addr  <= op.addr;
      // Write view only for writes, reads carry no data
      mem_req.wdata <= op.write ? op.payload.wr_view.wdata : '0;
      // Strobes come already masked from decode
      mem_req.wstrb <= op.payload.wr_view.wstrb;
    end
  end

  // -------------------------------------------------------------------------
  // Result, one cycle after the reply
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= reply;
    end
    if (reply) begin
      result.cmd  <= op_q.cmd;
      result.addr <= op_q.addr;
      // Writes echo their data, reads return memory data and tag
      result.data <= op_q.write ? op_q.payload.wr_view.wdata : mem_rsp.rdata;
      result.tag  <= op_q.write ? '0 : op_q.payload.rd_view.tag;
    end
  end

  // Marks the entry as live inside the response queue
  assign result.valid = result_valid;

endmodule : mem_execute

// File: design/resp_result.sv
// -------------------------------------------------------------------------
// Response result stage
// Queues completed accesses and presents the queue head to the consumer
// -------------------------------------------------------------------------

module resp_result (
  input  logic                     ap_clk,
  input  logic                     areset_m_axi,
  input  logic                     result_valid,
  input  cmd_buffer_pkg::cmd_rsp_t result,
  input  logic                     resp_ready,
  output cmd_buffer_pkg::cmd_rsp_t resp_out,
  output logic                     resp_space,
  output logic                     resp_empty
);

  cmd_buffer_pkg::cmd_rsp_t rsp_head;
  logic                     rsp_pop;
  logic                     rsp_prog_full;

  // Pop the head whenever the consumer is ready
  assign rsp_pop = resp_ready & ~resp_empty;

  // Execute holds off at programmable-full
  assign resp_space = ~rsp_prog_full;

  // -------------------------------------------------------------------------
  // Response queue
  // -------------------------------------------------------------------------
  cmd_fifo #(
    .WIDTH($bits(cmd_buffer_pkg::cmd_rsp_t)),
    .DEPTH(cmd_buffer_pkg::FIFO_DEPTH)
  ) u_rsp_fifo (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .din         (result),
    .push        (result_valid),
    .pop         (rsp_pop),
    .dout        (rsp_head),
    .full        (),
    .empty       (resp_empty),
    .prog_full   (rsp_prog_full)
  );

  // Head payload, valid follows occupancy
  always_comb begin
    resp_out       = rsp_head;
    resp_out.valid = ~resp_empty;
  end

endmodule : resp_result

// File: verif/cmd_buffer_properties.sv
// ---------------------------------------------------------------------------
// Command buffer assertions
// Memory port pacing, response state after reset and the drain flag
// ---------------------------------------------------------------------------

module cmd_buffer_properties (
  input logic ap_clk,
  input logic areset_m_axi,
  input logic mem_req_valid,
  input logic mem_rsp_valid,
  input logic resp_out_valid,
  input logic done_out
);
  timeunit 1ns;
  timeprecision 1ps;

  // Access issued and not yet answered
  logic req_open;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      req_open <= 1'b0;
    end else if (mem_req_valid) begin
      req_open <= 1'b1;
    end else if (mem_rsp_valid) begin
      req_open <= 1'b0;
    end
  end

  a_one_req_per_reply : assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) mem_req_valid |-> !req_open
  ) else $error("memory request issued while an earlier one is unanswered");

  a_resp_idle_after_reset : assert property (
    @(posedge ap_clk) $fell(areset_m_axi) |-> !resp_out_valid
  ) else $error("response valid in the first cycle after reset");

  // Drain flag never overlaps a waiting response
  a_done_without_resp : assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) !(done_out && resp_out_valid)
  ) else $error("done_out high while a response is still queued");

endmodule : cmd_buffer_properties

bind cmd_buffer_top cmd_buffer_properties u_props (
  .ap_clk        (ap_clk),
  .areset_m_axi  (areset_m_axi),
  .mem_req_valid (mem_req.valid),
  .mem_rsp_valid (mem_rsp.valid),
  .resp_out_valid(resp_out.valid),
  .done_out      (done_out)
);

// File: verif/cmd_buffer_tb.sv
// ---------------------------------------------------------------------------
// Command buffer testbench
// Drives a command table through the buffer against a strobe-merging
// memory model and checks every response in order
// ---------------------------------------------------------------------------

module cmd_buffer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // ---------------------------------------------------------------------------
  // Table sizing
  // ---------------------------------------------------------------------------
  localparam int BURST_START = 16;
  localparam int BURST_LEN   = 32;
  localparam int TABLE_LEN   = BURST_START + BURST_LEN;
  // Consumer stall, long enough to fill the response queue at the slowest reply
  localparam int HOLD_CYCLES = cmd_buffer_pkg::PROG_THRESH * 10;
  // 20 cycles of 20 ns per table entry
  localparam int WATCHDOG_NS = TABLE_LEN * 20 * 20;

  // One table row, stimulus plus expected response
  typedef struct packed {
    logic [1:0]                          cmd;
    logic [cmd_buffer_pkg::ADDR_W-1:0]   addr;
    logic [cmd_buffer_pkg::PAYLOAD_W-1:0] payload;
    logic [cmd_buffer_pkg::DATA_W-1:0]   exp_data;
    logic [cmd_buffer_pkg::TAG_W-1:0]    exp_tag;
  } tbl_entry_t;

  logic                     ap_clk;
  logic                     areset_m_axi;
  cmd_buffer_pkg::cmd_req_t cmd_in;
  logic                     cmd_prog_full;
  cmd_buffer_pkg::mem_req_t mem_req;
  cmd_buffer_pkg::mem_rsp_t mem_rsp;
  cmd_buffer_pkg::cmd_rsp_t resp_out;
  logic                     resp_ready;
  logic                     done_out;

  tbl_entry_t  table_q[$];
  tbl_entry_t  exp_q[$];
  // Reference memory for expected data, separate from the model's storage
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] mem_store [logic [31:0]];
  logic        rsp_pending;
  int          rsp_wait;
  logic [31:0] rsp_data;
  logic        saw_prog_full;

  always #10 ap_clk = ~ap_clk;

  cmd_buffer_top dut0 (
    .ap_clk       (ap_clk),
    .areset_m_axi (areset_m_axi),
    .cmd_in       (cmd_in),
    .cmd_prog_full(cmd_prog_full),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .resp_out     (resp_out),
    .resp_ready   (resp_ready),
    .done_out     (done_out)
  );

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  // Byte lanes with a set strobe take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] word;
    int          b;
    word = old_word;
    for (b = 0; b < 4; b++) begin
      if (wstrb[b]) word[8*b +: 8] = wdata[8*b +: 8];
    end
    return word;
  endfunction

  task automatic abort_run;
    $display("test failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Appends a row and works out its expected response
  task automatic add_entry(input logic [1:0] cmd, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb,
                           input logic [7:0] tag);
    tbl_entry_t  e;
    logic [31:0] old_word;
    old_word = ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
    e.cmd    = cmd;
    e.addr   = addr;
    if (cmd == cmd_buffer_pkg::CMD_MEM_WRITE) begin
      e.payload     = {wdata, wstrb};
      e.exp_data    = wdata;
      e.exp_tag     = 8'h00;
      ref_mem[addr] = merge_bytes(old_word, wdata, wstrb);
    end else begin
      // Tag on top, padding below
      e.payload  = {tag, 28'h0};
      e.exp_data = old_word;
      e.exp_tag  = tag;
    end
    table_q.push_back(e);
    // Unknown codes never answer
    if (cmd == cmd_buffer_pkg::CMD_MEM_WRITE || cmd == cmd_buffer_pkg::CMD_MEM_READ) begin
      exp_q.push_back(e);
    end
  endtask

  // Mixed rows over four words, one in eight an unknown code
  task automatic add_random(input int n);
    int          kind;
    logic [31:0] addr;
    repeat (n) begin
      kind = $urandom_range(7, 0);
      addr = 32'h100 + 32'(4 * $urandom_range(3, 0));
      if (kind == 0) begin
        add_entry(2'd3, addr, 32'h0, 4'h0, 8'h00);
      end else if (kind < 4) begin
        add_entry(cmd_buffer_pkg::CMD_MEM_READ, addr, 32'h0, 4'h0, 8'($urandom));
      end else begin
        add_entry(cmd_buffer_pkg::CMD_MEM_WRITE, addr, $urandom,
                  4'($urandom_range(15, 1)), 8'h00);
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // Memory model, one access at a time, 1 to 4 cycles to answer
  // ---------------------------------------------------------------------------
  always @(posedge ap_clk) begin
    mem_rsp.valid <= 1'b0;
    if (areset_m_axi) begin
      rsp_pending <= 1'b0;
    end else if (rsp_pending) begin
      if (rsp_wait == 0) begin
        mem_rsp.valid <= 1'b1;
        mem_rsp.rdata <= rsp_data;
        rsp_pending   <= 1'b0;
      end else begin
        rsp_wait <= rsp_wait - 1;
      end
    end else if (mem_req.valid) begin
      rsp_pending <= 1'b1;
      rsp_wait    <= $urandom_range(3, 0);
      if (mem_req.write) begin
        mem_store[mem_req.addr] = merge_bytes(
          mem_store.exists(mem_req.addr) ? mem_store[mem_req.addr] : 32'h0,
          mem_req.wdata, mem_req.wstrb);
        rsp_data <= 32'h0;
      end else begin
        // Reads never carry byte enables
        check_value("mem_req.wstrb", mem_req.wstrb, 4'h0);
        rsp_data <= mem_store.exists(mem_req.addr) ? mem_store[mem_req.addr] : 32'h0;
      end
    end
  end

  // Response monitor and overflow watch
  always @(posedge ap_clk) begin
    if (!areset_m_axi) begin
      if ((dut0.u_req_fifo.full && dut0.u_req_fifo.push) ||
          (dut0.u_result.u_rsp_fifo.full && dut0.u_result.u_rsp_fifo.push)) begin
        $display("Queue overflow, an entry was pushed into a full queue");
        abort_run();
      end
      if (resp_out.valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with no command left to answer");
          abort_run();
        end else begin
          check_value("resp_out.cmd", resp_out.cmd, exp_q[0].cmd);
          check_value("resp_out.addr", resp_out.addr, exp_q[0].addr);
          check_value("resp_out.data", resp_out.data, exp_q[0].exp_data);
          check_value("resp_out.tag", resp_out.tag, exp_q[0].exp_tag);
          exp_q.delete(0);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the buffer never drained", WATCHDOG_NS);
    abort_run();
  end

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------
  initial begin
    int cycle;
    int idx;
    int stall;
    void'($urandom(17093));
    ap_clk        = 1'b0;
    areset_m_axi  = 1'b1;
    cmd_in        = '0;
    mem_rsp       = '0;
    resp_ready    = 1'b0;
    saw_prog_full = 1'b0;
    stall         = 0;

    // Full write, then partial strobes over an unwritten word
    add_entry(cmd_buffer_pkg::CMD_MEM_WRITE, 32'h100, 32'h1122_3344, 4'hf, 8'h00);
    add_entry(cmd_buffer_pkg::CMD_MEM_READ, 32'h100, 32'h0, 4'h0, 8'h01);
    add_entry(cmd_buffer_pkg::CMD_MEM_WRITE, 32'h104, 32'haabb_ccdd, 4'h5, 8'h00);
    add_entry(cmd_buffer_pkg::CMD_MEM_WRITE, 32'h104, 32'h9988_7766, 4'h8, 8'h00);
    add_entry(cmd_buffer_pkg::CMD_MEM_READ, 32'h104, 32'h0, 4'h0, 8'h02);
    add_entry(2'd0, 32'h108, 32'h0, 4'h0, 8'h00);
    add_entry(cmd_buffer_pkg::CMD_MEM_READ, 32'h10c, 32'h0, 4'h0, 8'h03);
    add_entry(2'd3, 32'h100, 32'h0, 4'h0, 8'h7f);
    add_entry(cmd_buffer_pkg::CMD_MEM_WRITE, 32'h100, 32'h0000_ee00, 4'h2, 8'h00);
    add_entry(cmd_buffer_pkg::CMD_MEM_READ, 32'h100, 32'h0, 4'h0, 8'h04);
    add_random(BURST_START - 10);
    add_random(BURST_LEN);

    // Reset, done_out held low
    for (cycle = 0; cycle < 3; cycle++) begin
      @(posedge ap_clk);
      if (cycle > 0) check_value("done_out", done_out, 1'b0);
    end
    areset_m_axi <= 1'b0;
    resp_ready   <= 1'b1;

    for (idx = 0; idx < TABLE_LEN; idx++) begin
      @(posedge ap_clk);
      // Burst with the consumer stalled
      if (idx == BURST_START) resp_ready <= 1'b0;
      while (cmd_prog_full) begin
        cmd_in.valid <= 1'b0;
        if (idx >= BURST_START) begin
          saw_prog_full = 1'b1;
          stall++;
          if (stall == HOLD_CYCLES) resp_ready <= 1'b1;
        end
        @(posedge ap_clk);
      end
      cmd_in.valid   <= 1'b1;
      cmd_in.cmd     <= cmd_buffer_pkg::cmd_e'(table_q[idx].cmd);
      cmd_in.addr    <= table_q[idx].addr;
      cmd_in.payload <= table_q[idx].payload;
    end
    @(posedge ap_clk);
    cmd_in.valid <= 1'b0;
    resp_ready   <= 1'b1;
    check_value("cmd_prog_full", saw_prog_full, 1'b1);

    // Drain, then nothing more may show up
    while (!done_out) @(posedge ap_clk);
    check_value("responses outstanding", exp_q.size(), 0);
    repeat (5) begin
      @(posedge ap_clk);
      check_value("resp_out.valid", resp_out.valid, 1'b0);
    end
    $display("test passed");
    $finish;
  end

endmodule : cmd_buffer_tb

// File: verilog.f
design/cmd_buffer_pkg.sv
design/cmd_fifo.sv
design/cmd_decode.sv
design/mem_execute.sv
design/resp_result.sv
design/cmd_buffer_top.sv
verif/cmd_buffer_properties.sv
verif/cmd_buffer_tb.sv
